// ==== hdl/boot_image.hex ====
// boot image, one 16-bit hex word per line for words 0 to 31
7c01
0a10
3e02
1f20
4a05
0003
8c11
2b40
6d07
5e12
0f31
9a22
c104
3d50
7e13
e801
1a09
4f62
b330
2c18
d005
6a71
0e2f
8b44
f10c
3905
a7d2
5c36
0b8e
91f0
2e4a
c3a7

// ==== mem_subsystem.f ====
hdl/mem_pkg.sv
hdl/mem_req_queue.sv
hdl/mem_latency_timer.sv
hdl/mem_access_ctrl.sv
hdl/mem_array.sv
hdl/mem_subsystem.sv
dv/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - hdl/mem_pkg.sv
  - hdl/mem_req_queue.sv
  - hdl/mem_latency_timer.sv
  - hdl/mem_access_ctrl.sv
  - hdl/mem_array.sv
  - hdl/mem_subsystem.sv
  - target: test
    files:
      - dv/tb_mem_subsystem.sv

// ==== dv/tb_mem_subsystem.sv ====
module tb_mem_subsystem import mem_pkg::*; ();

	localparam int boot_reads = 128;
	localparam int write_count = 24;
	localparam int mix_count = 40;
	localparam int iso_count = 8;
	localparam int num_requests = boot_reads + 2 * write_count + 2 * mix_count + iso_count;
	localparam int timeout_cycles = (num_requests + 10) * (mem_latency + 2) * 2;

	typedef struct packed {
		mem_req_t req;
		int send_cycle;
		logic isolated;
	} pend_t;

	logic clk;
	logic reset_n;
	logic fetch_req_valid;
	mem_req_t fetch_req;
	logic fetch_credit_return;
	logic fetch_rsp_valid;
	mem_rsp_t fetch_rsp;
	logic data_req_valid;
	mem_req_t data_req;
	logic data_credit_return;
	logic data_rsp_valid;
	mem_rsp_t data_rsp;

	// reference model state
	word_t model_mem [mem_words];
	pend_t fetch_pend [$];
	pend_t data_pend [$];
	mem_rsp_t fetch_exp [$];
	mem_rsp_t data_exp [$];
	mem_req_t fetch_todo [$];
	mem_req_t data_todo [$];
	addr_t written [$];

	int fetch_credits;
	int data_credits;
	int fetch_sent;
	int data_sent;
	int fetch_returned;
	int data_returned;
	int cycle;
	int mismatch_count;
	int other_count;
	int last_ret_cycle;
	logic last_ret_port;
	logic any_ret;
	logic [15:0] lfsr_state;
	string phase_name;

	mem_subsystem mem_subsystem_inst (
		.clk(clk),
		.reset_n(reset_n),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req(fetch_req),
		.fetch_credit_return(fetch_credit_return),
		.fetch_rsp_valid(fetch_rsp_valid),
		.fetch_rsp(fetch_rsp),
		.data_req_valid(data_req_valid),
		.data_req(data_req),
		.data_credit_return(data_credit_return),
		.data_rsp_valid(data_rsp_valid),
		.data_rsp(data_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic mem_req_t fetch_request(input addr_t addr);
		mem_req_t r;
		r.write = 1'b0;
		r.addr = addr;
		r.wdata = '0;
		return r;
	endfunction

	// data traffic stays in the upper half away from fetch addresses
	function automatic mem_req_t data_request(input logic write);
		mem_req_t r;
		logic [31:0] bits;
		bits = rand_bits(7);
		r.write = write;
		r.addr = {1'b1, bits[6:0]};
		r.wdata = write ? word_t'(rand_bits(word_width)) : '0;
		return r;
	endfunction

	task automatic check_rsp(input string name, input mem_rsp_t expected, input mem_rsp_t actual);
		if (expected !== actual) begin
			mismatch_count++;
			$display("Mismatch %s: expected addr %h rdata %h, actual addr %h rdata %h",
				name, expected.addr, expected.rdata, actual.addr, actual.rdata);
		end
	endtask

	task automatic check_credit(input string name, input int expected, input int actual);
		if (expected != actual) begin
			mismatch_count++;
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (expected != actual) begin
			mismatch_count++;
			$display("Mismatch %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
		end
	endtask

	task automatic check_port(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			mismatch_count++;
			$display("Mismatch %s: expected port %0d, actual port %0d", name, expected, actual);
		end
	endtask

	task automatic report_error(input string msg);
		other_count++;
		$display("Error: %s", msg);
	endtask

	task automatic report_counts();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
	endtask

	// a credit return marks the commit of that port's oldest request
	task automatic apply_credit(input logic port);
		pend_t entry;
		mem_rsp_t exp_rsp;
		logic other_waiting;
		string name;
		name = $sformatf("%s %s", phase_name, (port == port_fetch) ? "fetch" : "data");
		if (port == port_fetch) begin
			fetch_credits++;
			fetch_returned++;
			if (fetch_pend.size() == 0) begin
				report_error("fetch credit return with no pending request");
				return;
			end
			entry = fetch_pend.pop_front();
			other_waiting = (data_pend.size() != 0) && (data_pend[0].send_cycle < last_ret_cycle);
		end else begin
			data_credits++;
			data_returned++;
			if (data_pend.size() == 0) begin
				report_error("data credit return with no pending request");
				return;
			end
			entry = data_pend.pop_front();
			other_waiting = (fetch_pend.size() != 0) && (fetch_pend[0].send_cycle < last_ret_cycle);
		end
		// other port had a head at the grant so the last granted port must yield
		if (any_ret && other_waiting) begin
			check_port({name, " grant"}, ~last_ret_port, port);
		end
		if (entry.isolated) begin
			check_latency({name, " latency"}, mem_latency + 3, cycle - entry.send_cycle);
		end
		if (entry.req.write) begin
			model_mem[entry.req.addr] = entry.req.wdata;
		end else begin
			exp_rsp.addr = entry.req.addr;
			exp_rsp.rdata = model_mem[entry.req.addr];
			if (port == port_fetch) begin
				fetch_exp.push_back(exp_rsp);
			end else begin
				data_exp.push_back(exp_rsp);
			end
		end
		last_ret_port = port;
		last_ret_cycle = cycle;
		any_ret = 1'b1;
	endtask

	task automatic take_rsp(input logic port, input mem_rsp_t actual);
		string name;
		name = $sformatf("%s %s rsp", phase_name, (port == port_fetch) ? "fetch" : "data");
		if (port == port_fetch && fetch_exp.size() == 0) begin
			report_error("fetch response with no expected entry");
		end else if (port == port_data && data_exp.size() == 0) begin
			report_error("data response with no expected entry");
		end else if (port == port_fetch) begin
			check_rsp(name, fetch_exp.pop_front(), actual);
		end else begin
			check_rsp(name, data_exp.pop_front(), actual);
		end
	endtask

	// credits are applied before responses so each read finds its expected entry
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (fetch_credit_return) begin
			apply_credit(port_fetch);
		end
		if (data_credit_return) begin
			apply_credit(port_data);
		end
		if (fetch_rsp_valid) begin
			take_rsp(port_fetch, fetch_rsp);
		end
		if (data_rsp_valid) begin
			take_rsp(port_data, data_rsp);
		end
		if (fetch_exp.size() != 0) begin
			report_error("fetch read response missing in its credit return cycle");
			fetch_exp.delete();
		end
		if (data_exp.size() != 0) begin
			report_error("data read response missing in its credit return cycle");
			data_exp.delete();
		end
	end

	// send the queued requests under credit control and wait for all returns
	task automatic drive_traffic(input logic full_rate);
		logic fetch_go;
		logic data_go;
		logic isolated;
		pend_t entry;
		while (fetch_todo.size() != 0 || data_todo.size() != 0) begin
			@(posedge clk);
			fetch_go = (fetch_todo.size() != 0) && (fetch_credits > 0)
				&& (full_rate || rand_bits(1) != 0);
			data_go = (data_todo.size() != 0) && (data_credits > 0)
				&& (full_rate || rand_bits(1) != 0);
			isolated = (fetch_pend.size() == 0) && (data_pend.size() == 0)
				&& !(fetch_go && data_go);
			fetch_req_valid <= fetch_go;
			data_req_valid <= data_go;
			if (fetch_go) begin
				entry.req = fetch_todo.pop_front();
				entry.send_cycle = cycle + 1;
				entry.isolated = isolated;
				fetch_req <= entry.req;
				fetch_pend.push_back(entry);
				fetch_credits--;
				fetch_sent++;
			end
			if (data_go) begin
				entry.req = data_todo.pop_front();
				entry.send_cycle = cycle + 1;
				entry.isolated = isolated;
				data_req <= entry.req;
				data_pend.push_back(entry);
				data_credits--;
				data_sent++;
			end
		end
		@(posedge clk);
		fetch_req_valid <= 1'b0;
		data_req_valid <= 1'b0;
		while (fetch_pend.size() != 0 || data_pend.size() != 0) begin
			@(posedge clk);
		end
	endtask

	initial begin : watchdog
		int wd_count;
		wd_count = 0;
		while (wd_count < timeout_cycles) begin
			@(posedge clk);
			wd_count++;
		end
		other_count++;
		$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
		report_counts();
		$display("Test FAILED");
		$finish;
	end

	initial begin
		mem_req_t req;
		logic [31:0] bits;
		reset_n = 1'b0;
		fetch_req_valid = 1'b0;
		fetch_req = '0;
		data_req_valid = 1'b0;
		data_req = '0;
		lfsr_state = 16'd59548;
		cycle = 0;
		mismatch_count = 0;
		other_count = 0;
		fetch_credits = req_depth;
		data_credits = req_depth;
		fetch_sent = 0;
		data_sent = 0;
		fetch_returned = 0;
		data_returned = 0;
		last_ret_cycle = 0;
		last_ret_port = port_fetch;
		any_ret = 1'b0;
		for (int i = 0; i < mem_words; i++) begin
			model_mem[i] = '0;
		end
		$readmemh("hdl/boot_image.hex", model_mem, 0, boot_words - 1);
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);

		// boot image and untouched low memory
		phase_name = "boot";
		for (int a = 0; a < boot_reads; a++) begin
			fetch_todo.push_back(fetch_request(addr_t'(a)));
		end
		drive_traffic(1'b0);

		phase_name = "write_read";
		for (int i = 0; i < write_count; i++) begin
			req = data_request(1'b1);
			written.push_back(req.addr);
			data_todo.push_back(req);
		end
		drive_traffic(1'b0);
		for (int i = 0; i < written.size(); i++) begin
			req.write = 1'b0;
			req.addr = written[i];
			req.wdata = '0;
			data_todo.push_back(req);
		end
		drive_traffic(1'b0);

		// both ports loaded back to back
		phase_name = "mixed";
		for (int i = 0; i < mix_count; i++) begin
			bits = rand_bits(7);
			fetch_todo.push_back(fetch_request(addr_t'(bits[6:0])));
			data_todo.push_back(data_request(rand_bits(1) != 0));
		end
		drive_traffic(1'b1);

		phase_name = "isolated";
		for (int i = 0; i < iso_count; i++) begin
			repeat (rand_bits(2) + 1) @(posedge clk);
			if (i % 2 == 0) begin
				bits = rand_bits(7);
				fetch_todo.push_back(fetch_request(addr_t'(bits[6:0])));
			end else begin
				data_todo.push_back(data_request(rand_bits(1) != 0));
			end
			drive_traffic(1'b1);
		end

		// a stray credit return or response would show up within one access time
		repeat (mem_latency + 3) @(posedge clk);

		phase_name = "final";
		check_credit("final fetch credits", req_depth, fetch_credits);
		check_credit("final data credits", req_depth, data_credits);
		check_credit("fetch credit returns", fetch_sent, fetch_returned);
		check_credit("data credit returns", data_sent, data_returned);
		report_counts();
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== hdl/mem_subsystem.sv ====
module mem_subsystem import mem_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic fetch_req_valid,
	input mem_req_t fetch_req,
	output logic fetch_credit_return,
	output logic fetch_rsp_valid,
	output mem_rsp_t fetch_rsp,
	input logic data_req_valid,
	input mem_req_t data_req,
	output logic data_credit_return,
	output logic data_rsp_valid,
	output mem_rsp_t data_rsp
);

	logic fetch_head_valid;
	logic data_head_valid;
	mem_req_t fetch_head;
	mem_req_t data_head;
	logic fetch_pop;
	logic data_pop;

	logic timer_start;
	logic timer_done;

	logic array_en;
	logic array_write;
	addr_t array_addr;
	word_t array_wdata;
	word_t array_rdata;

	mem_req_queue fetch_queue (
		.clk(clk),
		.reset_n(reset_n),
		.req_valid(fetch_req_valid),
		.req(fetch_req),
		.pop(fetch_pop),
		.head_valid(fetch_head_valid),
		.head(fetch_head),
		.credit_return(fetch_credit_return)
	);

	mem_req_queue data_queue (
		.clk(clk),
		.reset_n(reset_n),
		.req_valid(data_req_valid),
		.req(data_req),
		.pop(data_pop),
		.head_valid(data_head_valid),
		.head(data_head),
		.credit_return(data_credit_return)
	);

	mem_access_ctrl mem_access_ctrl_inst (
		.clk(clk),
		.reset_n(reset_n),
		.fetch_head_valid(fetch_head_valid),
		.data_head_valid(data_head_valid),
		.fetch_head(fetch_head),
		.data_head(data_head),
		.fetch_pop(fetch_pop),
		.data_pop(data_pop),
		.timer_start(timer_start),
		.timer_done(timer_done),
		.array_en(array_en),
		.array_write(array_write),
		.array_addr(array_addr),
		.array_wdata(array_wdata),
		.array_rdata(array_rdata),
		.fetch_rsp_valid(fetch_rsp_valid),
		.data_rsp_valid(data_rsp_valid),
		.fetch_rsp(fetch_rsp),
		.data_rsp(data_rsp)
	);

	mem_latency_timer mem_latency_timer_inst (
		.clk(clk),
		.reset_n(reset_n),
		.start(timer_start),
		.done(timer_done)
	);

	mem_array mem_array_inst (
		.clk(clk),
		.en(array_en),
		.write(array_write),
		.addr(array_addr),
		.wdata(array_wdata),
		.rdata(array_rdata)
	);

endmodule

// ==== hdl/mem_array.sv ====
module mem_array import mem_pkg::*; (
	input logic clk,
	input logic en,
	input logic write,
	input addr_t addr,
	input word_t wdata,
	output word_t rdata
);

	word_t mem [mem_words];

	// upper words start out zero, boot image goes over the low ones
	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = '0;
		end
		$readmemh(boot_file, mem, 0, boot_words - 1);
	end

	// one access per cycle, read data is registered
	always_ff @(posedge clk) begin
		if (en) begin
			if (write) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== hdl/mem_access_ctrl.sv ====
module mem_access_ctrl import mem_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic fetch_head_valid,
	input logic data_head_valid,
	input mem_req_t fetch_head,
	input mem_req_t data_head,
	output logic fetch_pop,
	output logic data_pop,
	output logic timer_start,
	input logic timer_done,
	output logic array_en,
	output logic array_write,
	output addr_t array_addr,
	output word_t array_wdata,
	input word_t array_rdata,
	output logic fetch_rsp_valid,
	output logic data_rsp_valid,
	output mem_rsp_t fetch_rsp,
	output mem_rsp_t data_rsp
);

	ctrl_state_t state;
	logic grant_q;
	logic pick;
	logic any_head;
	logic rsp_pending;
	mem_req_t req_q;

	assign any_head = fetch_head_valid | data_head_valid;

	// round robin, the port not granted last wins a tie
	always_comb begin
		if (fetch_head_valid && data_head_valid) begin
			pick = ~grant_q;
		end else if (fetch_head_valid) begin
			pick = port_fetch;
		end else begin
			pick = port_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ctrl_idle;
			grant_q <= port_fetch;
			rsp_pending <= 1'b0;
		end else begin
			rsp_pending <= 1'b0;
			case (state)
				ctrl_idle: begin
					if (any_head) begin
						state <= ctrl_wait;
						grant_q <= pick;
					end
				end
				ctrl_wait: begin
					if (timer_done) begin
						state <= ctrl_commit;
					end
				end
				ctrl_commit: begin
					state <= ctrl_idle;
					rsp_pending <= ~req_q.write;
				end
				default: begin
					state <= ctrl_idle;
				end
			endcase
		end
	end

	// hold the granted request, the queue head may move after the pop
	always_ff @(posedge clk) begin
		if (state == ctrl_idle && any_head) begin
			req_q <= (pick == port_fetch) ? fetch_head : data_head;
		end
	end

	assign timer_start = (state == ctrl_idle) && any_head;

	assign array_en = (state == ctrl_commit);
	assign array_write = (state == ctrl_commit) && req_q.write;
	assign array_addr = req_q.addr;
	assign array_wdata = req_q.wdata;

	assign fetch_pop = (state == ctrl_commit) && (grant_q == port_fetch);
	assign data_pop = (state == ctrl_commit) && (grant_q == port_data);

	// req_q and grant_q still hold the committed access in the idle cycle after it
	assign fetch_rsp_valid = rsp_pending && (grant_q == port_fetch);
	assign data_rsp_valid = rsp_pending && (grant_q == port_data);
	assign fetch_rsp = '{addr: req_q.addr, rdata: array_rdata};
	assign data_rsp = '{addr: req_q.addr, rdata: array_rdata};

endmodule

// ==== hdl/mem_latency_timer.sv ====
module mem_latency_timer import mem_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic start,
	output logic done
);

	lat_cnt_t count;

	// zero means idle
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			count <= '0;
		end else if (start) begin
			count <= lat_cnt_t'(mem_latency);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// last waiting cycle
	assign done = (count == lat_cnt_t'(1));

endmodule

// ==== hdl/mem_req_queue.sv ====
module mem_req_queue import mem_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic req_valid,
	input mem_req_t req,
	input logic pop,
	output logic head_valid,
	output mem_req_t head,
	output logic credit_return
);

	mem_req_t entries [req_depth];
	req_ptr_t wr_ptr;
	req_ptr_t rd_ptr;
	req_cnt_t count;

	function automatic req_ptr_t ptr_next(input req_ptr_t ptr);
		if (ptr == req_ptr_t'(req_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head = entries[rd_ptr];

	// no full check, the credit count keeps the requester in bounds
	always_ff @(posedge clk) begin
		if (req_valid) begin
			entries[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (req_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({req_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// one credit back per popped entry, a cycle after the pop
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;
		end
	end

endmodule

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

	// data path sizes
	localparam int word_width = 16;
	localparam int addr_width = 8;
	localparam int mem_words = 256;

	// boot image covers the low words only
	localparam int boot_words = 32;
	localparam string boot_file = "hdl/boot_image.hex";

	// cycles an access waits before it reaches the array
	localparam int mem_latency = 4;

	// entries per port queue, also the credits a requester starts with
	localparam int req_depth = 2;

	localparam int req_ptr_width = (req_depth > 1) ? $clog2(req_depth) : 1;
	localparam int req_cnt_width = $clog2(req_depth + 1);
	localparam int lat_cnt_width = $clog2(mem_latency + 1);

	// port indices for the round-robin grant
	localparam logic port_fetch = 1'b0;
	localparam logic port_data = 1'b1;

	typedef logic [word_width-1:0] word_t;
	typedef logic [addr_width-1:0] addr_t;

	typedef logic [req_ptr_width-1:0] req_ptr_t;
	typedef logic [req_cnt_width-1:0] req_cnt_t;
	typedef logic [lat_cnt_width-1:0] lat_cnt_t;

	// fetch port sends write low and wdata zero
	typedef struct packed {
		logic write;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		addr_t addr;
		word_t rdata;
	} mem_rsp_t;

	typedef enum logic [1:0] {
		ctrl_idle = 2'd0,
		ctrl_wait = 2'd1,
		ctrl_commit = 2'd2
	} ctrl_state_t;

endpackage
